// ==== src/mem_pkg.sv ====
//*********************************************************************
// shared widths and encodings for the memory stage and the L1.5 port
// operation code bit fields: [3] store, [2:1] size, [0] signed
// request, return and size codes follow the L1.5 message encoding
//*********************************************************************
`default_nettype none

package mem_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int L15_DATA_W = 64;   // one half of the response data
    localparam int MEM_OP_W   = 4;

    // bit positions inside the operation code
    localparam int OP_STORE_BIT  = 3;   // 1 store, 0 load
    localparam int OP_WORD_BIT   = 2;   // size bit 2
    localparam int OP_HALF_BIT   = 1;   // size bit 1
    localparam int OP_SIGNED_BIT = 0;   // sign extend on load

    // size field: word 11, half 01, byte 10
    localparam logic [MEM_OP_W-1:0] OP_NONE = 4'b0000;
    localparam logic [MEM_OP_W-1:0] OP_SW   = 4'b1111;
    localparam logic [MEM_OP_W-1:0] OP_SH   = 4'b1011;
    localparam logic [MEM_OP_W-1:0] OP_SB   = 4'b1101;
    localparam logic [MEM_OP_W-1:0] OP_LW   = 4'b0111;
    localparam logic [MEM_OP_W-1:0] OP_LH   = 4'b0011;
    localparam logic [MEM_OP_W-1:0] OP_LHU  = 4'b0010;
    localparam logic [MEM_OP_W-1:0] OP_LB   = 4'b0101;
    localparam logic [MEM_OP_W-1:0] OP_LBU  = 4'b0100;

    // request types towards the cache
    localparam logic [3:0] RQ_LOAD  = 4'b0000;
    localparam logic [3:0] RQ_STORE = 4'b0001;

    // return types from the cache
    localparam logic [3:0] RET_LOAD   = 4'b0000;
    localparam logic [3:0] RET_ST_ACK = 4'b0100;
    localparam logic [3:0] RET_INT    = 4'b0111;   // interrupt, never completes an op

    // message data size
    localparam int SIZE_W = 3;

    localparam logic [SIZE_W-1:0] SIZE_0B = 3'b000;
    localparam logic [SIZE_W-1:0] SIZE_1B = 3'b001;
    localparam logic [SIZE_W-1:0] SIZE_2B = 3'b010;
    localparam logic [SIZE_W-1:0] SIZE_4B = 3'b011;

endpackage

`default_nettype wire

// ==== src/load_align.sv ====
//*********************************************************************
// picks the load value out of the 128-bit response, purely combinational
// expects an aligned address for half and word loads
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  logic [mem_pkg::L15_DATA_W-1:0] l15_data_0,
    input  logic [mem_pkg::L15_DATA_W-1:0] l15_data_1,
    input  logic [3:0]                     addr_lo,
    input  logic [mem_pkg::MEM_OP_W-1:0]   load_op,
    output logic [mem_pkg::XLEN-1:0]       mem_out
);
    logic [mem_pkg::XLEN-1:0] lane;
    logic [mem_pkg::XLEN-1:0] swapped;
    logic [mem_pkg::XLEN-1:0] shifted;
    logic                     sign_ext;

    always_comb begin
        case (addr_lo[3:2])
            2'b00:   lane = l15_data_0[63:32];
            2'b01:   lane = l15_data_0[31:0];
            2'b10:   lane = l15_data_1[63:32];
            default: lane = l15_data_1[31:0];
        endcase
    end

    assign swapped  = {lane[7:0], lane[15:8], lane[23:16], lane[31:24]};
    assign shifted  = swapped >> {addr_lo[1:0], 3'b000};   // byte offset to bit 0
    assign sign_ext = load_op[mem_pkg::OP_SIGNED_BIT];

    always_comb begin
        case ({load_op[mem_pkg::OP_WORD_BIT], load_op[mem_pkg::OP_HALF_BIT]})
            2'b11:   mem_out = swapped;
            2'b01:   mem_out = {{16{sign_ext & shifted[15]}}, shifted[15:0]};
            2'b10:   mem_out = {{24{sign_ext & shifted[7]}}, shifted[7:0]};
            default: mem_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/mem_req_decode.sv ====
//*********************************************************************
// stage 5 of the memory pipe; holds its operation while stall_mem is high
// misaligned accesses give no byte enables and no valid request
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_req_decode (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic [mem_pkg::MEM_OP_W-1:0] mem_op,
    input  logic [mem_pkg::XLEN-1:0]     op_a,       // base address
    input  logic [mem_pkg::XLEN-1:0]     op_b,       // store source or I-immediate
    input  logic [mem_pkg::XLEN-1:0]     s_imm,
    input  logic                         stall_mem,
    output logic [mem_pkg::XLEN-1:0]     addr,
    output logic [mem_pkg::XLEN-1:0]     store_data,
    output logic [3:0]                   bw,
    output logic                         is_load,
    output logic                         req_valid,
    output logic                         m_op,
    output logic                         ld_misaligned,
    output logic                         st_misaligned,
    output logic [mem_pkg::MEM_OP_W-1:0] mem_op_q
);
    logic [mem_pkg::XLEN-1:0] op_a_r;
    logic [mem_pkg::XLEN-1:0] op_b_r;
    logic [mem_pkg::XLEN-1:0] s_imm_r;
    logic                     is_store;
    logic                     is_half;
    logic                     is_word;
    logic                     misaligned;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mem_op_q <= '0;
        end else if (!stall_mem) begin
            mem_op_q <= mem_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_mem) begin
            op_a_r  <= op_a;
            op_b_r  <= op_b;
            s_imm_r <= s_imm;
        end
    end

    assign is_store = mem_op_q[mem_pkg::OP_STORE_BIT];
    assign is_half  = mem_op_q[mem_pkg::OP_HALF_BIT];   // also set for word
    assign is_word  = mem_op_q[mem_pkg::OP_HALF_BIT] & mem_op_q[mem_pkg::OP_WORD_BIT];

    assign addr = is_store ? (op_a_r + s_imm_r) : (op_a_r + op_b_r);

    assign misaligned    = (is_half & addr[0]) | (is_word & addr[1]);
    assign m_op          = |mem_op_q;
    assign ld_misaligned = misaligned & ~is_store;
    assign st_misaligned = misaligned & is_store;
    assign req_valid     = m_op & ~misaligned;
    assign is_load       = m_op & ~is_store & ~misaligned;

    // bw[0] is the byte at address offset 0
    always_comb begin
        bw = 4'b0000;
        if (is_store && !misaligned) begin
            if (is_word) begin
                bw = 4'b1111;
            end else if (is_half) begin
                bw = addr[1] ? 4'b1100 : 4'b0011;
            end else if (mem_op_q[mem_pkg::OP_WORD_BIT]) begin
                bw = 4'b0001 << addr[1:0];
            end
        end
    end

    // replicate so every lane carries the stored value
    always_comb begin
        if (is_word) begin
            store_data = op_b_r;
        end else if (is_half) begin
            store_data = {2{op_b_r[15:0]}};
        end else begin
            store_data = {4{op_b_r[7:0]}};
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_req_hold.sv ====
//*********************************************************************
// stage 6 register of the decoded request, loads every cycle
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_req_hold (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic [mem_pkg::XLEN-1:0]     addr_s5,
    input  logic [mem_pkg::XLEN-1:0]     store_data_s5,
    input  logic [3:0]                   bw_s5,
    input  logic                         is_load_s5,
    input  logic                         req_valid_s5,
    input  logic                         m_op_s5,
    input  logic                         ld_misaligned_s5,
    input  logic                         st_misaligned_s5,
    input  logic [mem_pkg::MEM_OP_W-1:0] mem_op_s5,
    output logic [mem_pkg::XLEN-1:0]     addr_s6,
    output logic [mem_pkg::XLEN-1:0]     store_data_s6,
    output logic [3:0]                   bw_s6,
    output logic                         is_load_s6,
    output logic                         req_valid_s6,
    output logic                         m_op_s6,
    output logic                         ld_misaligned_s6,
    output logic                         st_misaligned_s6,
    output logic [mem_pkg::MEM_OP_W-1:0] mem_op_s6
);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            addr_s6          <= '0;
            store_data_s6    <= '0;
            bw_s6            <= '0;
            is_load_s6       <= 1'b0;
            req_valid_s6     <= 1'b0;
            m_op_s6          <= 1'b0;
            ld_misaligned_s6 <= 1'b0;
            st_misaligned_s6 <= 1'b0;
            mem_op_s6        <= '0;
        end else begin
            addr_s6          <= addr_s5;
            store_data_s6    <= store_data_s5;
            bw_s6            <= bw_s5;
            is_load_s6       <= is_load_s5;
            req_valid_s6     <= req_valid_s5;
            m_op_s6          <= m_op_s5;
            ld_misaligned_s6 <= ld_misaligned_s5;
            st_misaligned_s6 <= st_misaligned_s5;
            mem_op_s6        <= mem_op_s5;
        end
    end

endmodule

`default_nettype wire

// ==== src/l15_req_fsm.sv ====
//*********************************************************************
// L1.5 request/response controller, one outstanding request at a time
// l15_req_val is a level; header_ack at a rising edge accepts it
// only the return type matching the issued request ends the operation
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module l15_req_fsm (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic [mem_pkg::XLEN-1:0]         addr,
    input  logic [mem_pkg::XLEN-1:0]         store_data,
    input  logic [3:0]                       bw,
    input  logic                             is_load,
    input  logic                             req_valid,
    input  logic [mem_pkg::MEM_OP_W-1:0]     mem_op_q,
    input  logic                             l15_header_ack,
    input  logic                             l15_resp_val,
    input  logic [3:0]                       l15_returntype,
    input  logic [mem_pkg::L15_DATA_W-1:0]   l15_data_0,
    input  logic [mem_pkg::L15_DATA_W-1:0]   l15_data_1,
    output logic [3:0]                       l15_rqtype,
    output logic [mem_pkg::SIZE_W-1:0]       l15_size,
    output logic [mem_pkg::XLEN-1:0]         l15_address,
    output logic [mem_pkg::L15_DATA_W-1:0]   l15_data,
    output logic                             l15_req_val,
    output logic                             l15_req_ack,
    output logic [mem_pkg::XLEN-1:0]         mem_out,
    output logic                             memop_done
);
    logic                         in_resp;     // low in request state, high in response state
    logic                         accept;
    logic                         ret_match;
    logic [3:0]                   rq_type_q;
    logic [mem_pkg::MEM_OP_W-1:0] op_q;
    logic [3:0]                   addr_lo_q;
    logic [mem_pkg::XLEN-1:0]     store_swap;

    // cache side is big endian
    assign store_swap = {store_data[7:0], store_data[15:8],
                         store_data[23:16], store_data[31:24]};

    assign l15_rqtype  = (|bw) ? mem_pkg::RQ_STORE : mem_pkg::RQ_LOAD;
    assign l15_address = addr;
    assign l15_data    = {store_swap, store_swap};
    assign l15_req_val = ~in_resp & req_valid;
    assign l15_req_ack = l15_resp_val;

    always_comb begin
        if (is_load) begin
            l15_size = mem_pkg::SIZE_4B;   // loads always fetch the word
        end else begin
            case (bw)
                4'b1111:                            l15_size = mem_pkg::SIZE_4B;
                4'b0011, 4'b1100:                   l15_size = mem_pkg::SIZE_2B;
                4'b0001, 4'b0010, 4'b0100, 4'b1000: l15_size = mem_pkg::SIZE_1B;
                default:                            l15_size = mem_pkg::SIZE_0B;
            endcase
        end
    end

    assign accept = l15_req_val & l15_header_ack;

    always_comb begin
        case (rq_type_q)
            mem_pkg::RQ_LOAD:  ret_match = (l15_returntype == mem_pkg::RET_LOAD);
            mem_pkg::RQ_STORE: ret_match = (l15_returntype == mem_pkg::RET_ST_ACK);
            default:           ret_match = 1'b0;
        endcase
    end

    assign memop_done = in_resp & l15_resp_val & ret_match;

    // context of the accepted request, the stage 6 copy may move on
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            in_resp   <= 1'b0;
            rq_type_q <= mem_pkg::RQ_LOAD;
            op_q      <= '0;
            addr_lo_q <= '0;
        end else if (accept) begin
            in_resp   <= 1'b1;
            rq_type_q <= l15_rqtype;
            op_q      <= mem_op_q;
            addr_lo_q <= addr[3:0];
        end else if (memop_done) begin
            in_resp <= 1'b0;
        end
    end

    load_align load_align_i (
        .l15_data_0 (l15_data_0),
        .l15_data_1 (l15_data_1),
        .addr_lo    (addr_lo_q),
        .load_op    (op_q),
        .mem_out    (mem_out)
    );

endmodule

`default_nettype wire

// ==== src/mem_wrap.sv ====
//*********************************************************************
// memory stage top; request fields are valid 2 edges after presentation
// the core keeps stall_mem high until memop_done
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_wrap (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic [mem_pkg::MEM_OP_W-1:0]   mem_op,
    input  logic [mem_pkg::XLEN-1:0]       op_a,
    input  logic [mem_pkg::XLEN-1:0]       op_b,
    input  logic [mem_pkg::XLEN-1:0]       s_imm,
    input  logic                           stall_mem,
    output logic [3:0]                     l15_rqtype,
    output logic [mem_pkg::SIZE_W-1:0]     l15_size,
    output logic [mem_pkg::XLEN-1:0]       l15_address,
    output logic [mem_pkg::L15_DATA_W-1:0] l15_data,
    output logic                           l15_req_val,
    output logic                           l15_req_ack,
    input  logic                           l15_header_ack,
    input  logic                           l15_resp_val,
    input  logic [3:0]                     l15_returntype,
    input  logic [mem_pkg::L15_DATA_W-1:0] l15_data_0,
    input  logic [mem_pkg::L15_DATA_W-1:0] l15_data_1,
    output logic [mem_pkg::XLEN-1:0]       mem_out,
    output logic                           memop_done,
    output logic                           m_op,
    output logic                           ld_misaligned,
    output logic                           st_misaligned
);
    logic [mem_pkg::XLEN-1:0]     addr_s5, addr_s6;
    logic [mem_pkg::XLEN-1:0]     store_data_s5, store_data_s6;
    logic [3:0]                   bw_s5, bw_s6;
    logic                         is_load_s5, is_load_s6;
    logic                         req_valid_s5, req_valid_s6;
    logic                         m_op_s5;
    logic                         ld_misaligned_s5;
    logic                         st_misaligned_s5;
    logic [mem_pkg::MEM_OP_W-1:0] mem_op_s5, mem_op_s6;

    mem_req_decode mem_req_decode_i (
        .clk           (clk),
        .nrst          (nrst),
        .mem_op        (mem_op),
        .op_a          (op_a),
        .op_b          (op_b),
        .s_imm         (s_imm),
        .stall_mem     (stall_mem),
        .addr          (addr_s5),
        .store_data    (store_data_s5),
        .bw            (bw_s5),
        .is_load       (is_load_s5),
        .req_valid     (req_valid_s5),
        .m_op          (m_op_s5),
        .ld_misaligned (ld_misaligned_s5),
        .st_misaligned (st_misaligned_s5),
        .mem_op_q      (mem_op_s5)
    );

    mem_req_hold mem_req_hold_i (
        .clk              (clk),
        .nrst             (nrst),
        .addr_s5          (addr_s5),
        .store_data_s5    (store_data_s5),
        .bw_s5            (bw_s5),
        .is_load_s5       (is_load_s5),
        .req_valid_s5     (req_valid_s5),
        .m_op_s5          (m_op_s5),
        .ld_misaligned_s5 (ld_misaligned_s5),
        .st_misaligned_s5 (st_misaligned_s5),
        .mem_op_s5        (mem_op_s5),
        .addr_s6          (addr_s6),
        .store_data_s6    (store_data_s6),
        .bw_s6            (bw_s6),
        .is_load_s6       (is_load_s6),
        .req_valid_s6     (req_valid_s6),
        .m_op_s6          (m_op),
        .ld_misaligned_s6 (ld_misaligned),
        .st_misaligned_s6 (st_misaligned),
        .mem_op_s6        (mem_op_s6)
    );

    l15_req_fsm l15_req_fsm_i (
        .clk            (clk),
        .nrst           (nrst),
        .addr           (addr_s6),
        .store_data     (store_data_s6),
        .bw             (bw_s6),
        .is_load        (is_load_s6),
        .req_valid      (req_valid_s6),
        .mem_op_q       (mem_op_s6),
        .l15_header_ack (l15_header_ack),
        .l15_resp_val   (l15_resp_val),
        .l15_returntype (l15_returntype),
        .l15_data_0     (l15_data_0),
        .l15_data_1     (l15_data_1),
        .l15_rqtype     (l15_rqtype),
        .l15_size       (l15_size),
        .l15_address    (l15_address),
        .l15_data       (l15_data),
        .l15_req_val    (l15_req_val),
        .l15_req_ack    (l15_req_ack),
        .mem_out        (mem_out),
        .memop_done     (memop_done)
    );

endmodule

`default_nettype wire

// ==== verif/mem_wrap_tb.sv ====
//**********************************************************************
// one operation in flight at a time, following the core stall convention
// the cache side is answered in-line; it never acks a stale request
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_wrap_tb;
    localparam int NUM_OPS      = 200;
    localparam int REQ_TIMEOUT  = 20;

    logic                           clk;
    logic                           nrst;
    logic [mem_pkg::MEM_OP_W-1:0]   mem_op;
    logic [mem_pkg::XLEN-1:0]       op_a, op_b, s_imm;
    logic                           stall_mem;
    logic                           l15_header_ack, l15_resp_val;
    logic [3:0]                     l15_returntype, l15_rqtype;
    logic [mem_pkg::L15_DATA_W-1:0] l15_data_0, l15_data_1, l15_data;
    logic [mem_pkg::SIZE_W-1:0]     l15_size;
    logic [mem_pkg::XLEN-1:0]       l15_address, mem_out;
    logic                           l15_req_val, l15_req_ack, memop_done;
    logic                           m_op, ld_misaligned, st_misaligned;
    logic [15:0]                    lfsr;
    logic [mem_pkg::MEM_OP_W-1:0]   op_list [8];

    mem_wrap mem_wrap_i (
        .clk(clk), .nrst(nrst), .mem_op(mem_op), .op_a(op_a), .op_b(op_b),
        .s_imm(s_imm), .stall_mem(stall_mem),
        .l15_rqtype(l15_rqtype), .l15_size(l15_size), .l15_address(l15_address),
        .l15_data(l15_data), .l15_req_val(l15_req_val), .l15_req_ack(l15_req_ack),
        .l15_header_ack(l15_header_ack), .l15_resp_val(l15_resp_val),
        .l15_returntype(l15_returntype), .l15_data_0(l15_data_0),
        .l15_data_1(l15_data_1), .mem_out(mem_out), .memop_done(memop_done),
        .m_op(m_op), .ld_misaligned(ld_misaligned), .st_misaligned(st_misaligned)
    );

    always #20 clk = ~clk;

    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int op_width(input logic [3:0] op);
        case (op)
            mem_pkg::OP_SW, mem_pkg::OP_LW:                  return 4;
            mem_pkg::OP_SH, mem_pkg::OP_LH, mem_pkg::OP_LHU: return 2;
            default:                                         return 1;
        endcase
    endfunction

    function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // line bytes sit in address order, value is assembled little endian
    function automatic logic [31:0] load_model(input logic [127:0] line,
                                               input logic [3:0] idx,
                                               input logic [3:0] op);
        logic [31:0] word;
        logic [31:0] sh;
        int          base;
        base = 4 * int'(idx[3:2]);
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = line[127 - 8 * (base + i) -: 8];
        end
        sh = word >> (8 * idx[1:0]);
        case (op)
            mem_pkg::OP_LB:  return {{24{sh[7]}}, sh[7:0]};
            mem_pkg::OP_LBU: return {24'h0, sh[7:0]};
            mem_pkg::OP_LH:  return {{16{sh[15]}}, sh[15:0]};
            mem_pkg::OP_LHU: return {16'h0, sh[15:0]};
            default:         return word;
        endcase
    endfunction

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic fail_run(input string what);
        $display("ERROR: %s", what);
        stop_run();
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic scramble_inputs();
        mem_op = 4'(rand_bits(4));
        op_a   = rand_bits(32);
        op_b   = rand_bits(32);
        s_imm  = rand_bits(32);
    endtask

    // drive point is 2 ns after the edge; stalled inputs get garbage
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (stall_mem) begin
            scramble_inputs();
        end
    endtask

    task automatic check_idle_outputs();
        check_val("l15_req_val", 64'(l15_req_val), 64'(0));
        check_val("memop_done", 64'(memop_done), 64'(0));
        check_val("m_op", 64'(m_op), 64'(0));
        check_val("ld_misaligned", 64'(ld_misaligned), 64'(0));
        check_val("st_misaligned", 64'(st_misaligned), 64'(0));
    endtask

    task automatic run_op();
        logic [3:0]   op;
        logic         want_mis, is_store, mis;
        logic [31:0]  a, b, imm, off, addr, stored;
        logic [1:0]   lo;
        logic [2:0]   size;
        logic [63:0]  d0, d1;
        int           width;
        int           n;
        op       = op_list[3'(rand_bits(3))];
        width    = op_width(op);
        is_store = (op == mem_pkg::OP_SW) || (op == mem_pkg::OP_SH) || (op == mem_pkg::OP_SB);
        want_mis = rand_bits(1) == 32'd1;
        a        = rand_bits(32);
        b        = rand_bits(32);
        imm      = rand_bits(32);
        off      = is_store ? imm : b;
        lo       = 2'(rand_bits(2));
        if (width == 4) begin
            lo = want_mis ? ((lo == 2'b00) ? 2'b10 : lo) : 2'b00;
        end else if (width == 2) begin
            lo = {lo[1], want_mis};
        end
        a[1:0] = lo - off[1:0];   // force the low address bits
        addr   = a + off;
        mis    = (width == 4 && addr[1:0] != 2'b00) || (width == 2 && addr[0]);
        size   = !is_store ? mem_pkg::SIZE_4B : (width == 4) ? mem_pkg::SIZE_4B :
                 (width == 2) ? mem_pkg::SIZE_2B : mem_pkg::SIZE_1B;
        stored = (width == 4) ? b : (width == 2) ? {2{b[15:0]}} : {4{b[7:0]}};

        mem_op    = op;
        op_a      = a;
        op_b      = b;
        s_imm     = imm;
        stall_mem = 1'b0;
        next_cycle();        // captured in stage 5
        stall_mem = 1'b1;
        scramble_inputs();
        next_cycle();        // now in stage 6
        check_val("m_op", 64'(m_op), 64'(1));
        check_val("ld_misaligned", 64'(ld_misaligned), 64'(mis & !is_store));
        check_val("st_misaligned", 64'(st_misaligned), 64'(mis & is_store));

        if (mis) begin
            repeat (10) begin
                check_val("l15_req_val", 64'(l15_req_val), 64'(0));
                check_val("memop_done", 64'(memop_done), 64'(0));
                next_cycle();
            end
        end else begin
            n = 0;
            while (!l15_req_val) begin
                if (n == REQ_TIMEOUT) fail_run("l15_req_val never rose for an aligned access");
                next_cycle();
                n++;
            end
            repeat (rand_bits(2)) next_cycle();   // cache back-pressure
            l15_header_ack = 1'b1;
            #1;
            check_val("l15_rqtype", 64'(l15_rqtype),
                      64'(is_store ? mem_pkg::RQ_STORE : mem_pkg::RQ_LOAD));
            check_val("l15_address", 64'(l15_address), 64'(addr));
            check_val("l15_size", 64'(l15_size), 64'(size));
            if (is_store) begin
                check_val("l15_data", l15_data, {reverse_bytes(stored), reverse_bytes(stored)});
            end
            next_cycle();
            l15_header_ack = 1'b0;
            check_val("l15_req_val", 64'(l15_req_val), 64'(0));
            check_val("l15_req_ack", 64'(l15_req_ack), 64'(0));
            repeat (rand_bits(2)) next_cycle();

            d0[63:32]  = rand_bits(32);
            d0[31:0]   = rand_bits(32);
            d1[63:32]  = rand_bits(32);
            d1[31:0]   = rand_bits(32);
            l15_data_0 = d0;
            l15_data_1 = d1;
            if (rand_bits(1) == 32'd1) begin
                // interrupt or the other op's return type first
                l15_returntype = (rand_bits(1) == 32'd1) ? mem_pkg::RET_INT :
                                 (is_store ? mem_pkg::RET_LOAD : mem_pkg::RET_ST_ACK);
                l15_resp_val   = 1'b1;
                #1;
                check_val("memop_done", 64'(memop_done), 64'(0));
                check_val("l15_req_ack", 64'(l15_req_ack), 64'(1));
                next_cycle();
            end
            l15_returntype = is_store ? mem_pkg::RET_ST_ACK : mem_pkg::RET_LOAD;
            l15_resp_val   = 1'b1;
            #1;
            check_val("memop_done", 64'(memop_done), 64'(1));
            check_val("l15_req_ack", 64'(l15_req_ack), 64'(1));
            if (!is_store) begin
                check_val("mem_out", 64'(mem_out), 64'(load_model({d0, d1}, addr[3:0], op)));
            end
            next_cycle();
            l15_resp_val = 1'b0;
        end
        // three idle slots flush the stale stage 6 request
        stall_mem = 1'b0;
        mem_op    = mem_pkg::OP_NONE;
        repeat (3) next_cycle();
    endtask

    initial begin
        lfsr           = 16'd71;
        clk            = 1'b0;
        nrst           = 1'b0;
        mem_op         = mem_pkg::OP_NONE;
        op_a           = '0;
        op_b           = '0;
        s_imm          = '0;
        stall_mem      = 1'b0;
        l15_header_ack = 1'b0;
        l15_resp_val   = 1'b0;
        l15_returntype = '0;
        l15_data_0     = '0;
        l15_data_1     = '0;
        op_list = '{mem_pkg::OP_SW, mem_pkg::OP_SH, mem_pkg::OP_SB, mem_pkg::OP_LW,
                    mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_LB, mem_pkg::OP_LBU};
        repeat (2) begin
            @(posedge clk);
            #2;
            check_idle_outputs();
        end
        nrst = 1'b1;
        #1;
        check_idle_outputs();
        next_cycle();
        check_idle_outputs();
        for (int i = 0; i < NUM_OPS; i++) begin
            run_op();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_wrap.f ====
src/mem_pkg.sv
src/load_align.sv
src/mem_req_decode.sv
src/mem_req_hold.sv
src/l15_req_fsm.sv
src/mem_wrap.sv
verif/mem_wrap_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
TOP       ?= mem_wrap_tb
RTL_TOP   ?= mem_wrap
FILELIST  ?= mem_wrap.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
